// ==== mem_subsys.f ====
+incdir+hdl
hdl/mem_pkg.sv
hdl/mem_req_if.sv
hdl/mmio_router.sv
hdl/data_cache.sv
hdl/bus_arbiter.sv
hdl/mem_subsys_top.sv
bench/bus_slave_model.sv
bench/mem_subsys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := mem_subsys_tb
FILELIST  := mem_subsys.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv,$(shell cat $(FILELIST))) $(wildcard hdl/*.svh)
PASS_TEXT := Simulation finished: PASS

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/mem_subsys_tb.sv ====
`timescale 1ns/1ns
`include "mem_macros.svh"

module mem_subsys_tb;
    localparam logic [31:0] seed_value   = 32'h1fd5_16e8;
    localparam int          num_accesses = 14;
    localparam logic [63:0] addr_a       = 64'h0000_0000_8000_0100;
    localparam logic [63:0] addr_b       = 64'h0000_0000_8000_0248;  // different line from addr_a
    localparam logic [63:0] addr_low     = 64'h0000_0000_01ff_fff8;  // just below the CLINT
    localparam logic [63:0] addr_uart    = `MEM_UART_START + 64'h8;
    localparam logic [63:0] addr_spictrl = `MEM_SPICTRL_START + 64'h10;
    localparam logic [63:0] addr_spi     = `MEM_SPI_START + 64'h20;
    localparam logic [63:0] addr_clint   = `MEM_CLINT_START + 64'h4000;

    logic                    clk;
    logic                    reset;
    logic [`MEM_XLEN-1:0]    core_addr;
    logic [`MEM_XLEN-1:0]    core_wdata;
    logic [`MEM_MASK_W-1:0]  core_mask;
    logic                    core_we;
    logic                    core_re;
    logic                    core_fence;
    logic [`MEM_XLEN-1:0]    core_rdata;
    logic                    core_finish;
    mem_pkg::access_region_e core_region;
    logic [`MEM_XLEN-1:0]    bus_addr;
    logic [`MEM_XLEN-1:0]    bus_wdata;
    logic [`MEM_MASK_W-1:0]  bus_mask;
    logic                    bus_we;
    logic                    bus_re;
    logic [`MEM_XLEN-1:0]    bus_rdata;
    logic                    bus_finish;

    integer                  seed;
    int                      errors;
    int                      errors_at_start;
    int                      tests_run;
    int                      tests_failed;
    string                   test_name;
    logic [31:0]             ref_words [logic [61:0]];
    logic [63:0]             log_addr [$];  // bus strobes seen during the current access
    logic [63:0]             log_wdata [$];
    logic [7:0]              log_mask [$];
    logic                    log_we [$];

    mem_subsys_top dut0 (.*);

    bus_slave_model #(.seed_init(seed_value)) slave0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic mem_pkg::access_region_e expected_region(input logic [63:0] a);
        if (a >= `MEM_CLINT_START && a <= `MEM_CLINT_END)
            return mem_pkg::REGION_CLINT;
        if ((a >= `MEM_UART_START && a <= `MEM_UART_END) ||
            (a >= `MEM_SPICTRL_START && a <= `MEM_SPICTRL_END) ||
            (a >= `MEM_SPI_START && a <= `MEM_SPI_END))
            return mem_pkg::REGION_DEVICE;
        return mem_pkg::REGION_MEMORY;
    endfunction

    // the slave starts every word with this pattern
    function automatic logic [31:0] fill_word(input logic [61:0] w);
        return w[31:0] ^ {2'b00, w[61:32]} ^ 32'h5ac3_0f69;
    endfunction

    function automatic logic [31:0] ref_word(input logic [61:0] w);
        return ref_words.exists(w) ? ref_words[w] : fill_word(w);
    endfunction

    // device registers split the same way, high word at base+4
    function automatic logic [63:0] ref_read(input logic [63:0] a);
        return {ref_word({a[63:3], 1'b1}), ref_word({a[63:3], 1'b0})};
    endfunction

    task automatic ref_write(input logic [63:0] a, input logic [63:0] wdata,
                             input logic [7:0] mask);
        logic [63:0] d;
        d = ref_read(a);
        for (int i = 0; i < 8; i++)
            if (mask[i])
                d[i*8 +: 8] = wdata[i*8 +: 8];
        ref_words[{a[63:3], 1'b0}] = d[31:0];
        ref_words[{a[63:3], 1'b1}] = d[63:32];
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
        else begin
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input logic ok, input string what);
        assert (ok)
        else begin
            $display("%s: %s", test_name, what);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    task automatic clear_log();
        log_addr.delete();
        log_wdata.delete();
        log_mask.delete();
        log_we.delete();
    endtask

    // counts cycles from the strobe until core_finish, sampled away from the rising edge
    task automatic wait_finish(output int cycles);
        cycles = 1;
        @(negedge clk);
        while (!core_finish) begin
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic run_access(input logic we, input logic [63:0] a, input logic [63:0] wdata,
                              input logic [7:0] mask, output logic [63:0] rdata,
                              output int cycles);
        clear_log();
        @(posedge clk);
        core_addr  <= a;
        core_wdata <= wdata;
        core_mask  <= mask;
        core_we    <= we;
        core_re    <= !we;
        @(posedge clk);
        core_we <= 1'b0;
        core_re <= 1'b0;
        wait_finish(cycles);
        rdata = core_rdata;
    endtask

    task automatic run_fence(output int cycles);
        clear_log();
        @(posedge clk);
        core_fence <= 1'b1;
        @(posedge clk);
        core_fence <= 1'b0;
        wait_finish(cycles);
    endtask

    task automatic check_split(input logic we, input logic [63:0] a, input logic [63:0] wdata,
                               input logic [7:0] mask);
        logic [63:0] base;
        base = {a[63:3], 3'b000};
        check_value("bus strobes", 64'd2, 64'(log_addr.size()));
        if (log_addr.size() == 2) begin
            check_flag(log_we[0] == we && log_we[1] == we, "beat direction differs from core");
            check_value("high beat addr", base + 64'd4, log_addr[0]);
            check_value("low beat addr", base, log_addr[1]);
            if (we) begin
                check_value("high beat data", 64'(wdata[63:32]), 64'(log_wdata[0][31:0]));
                check_value("high beat mask", 64'(mask[7:4]), 64'(log_mask[0][3:0]));
                check_value("low beat data", 64'(wdata[31:0]), 64'(log_wdata[1][31:0]));
                check_value("low beat mask", 64'(mask[3:0]), 64'(log_mask[1][3:0]));
            end
        end
    endtask

    task automatic read_and_check(input logic [63:0] a, input logic expect_hit);
        logic [63:0] rdata;
        int          cycles;
        run_access(1'b0, a, '0, '0, rdata, cycles);
        check_value("read data", ref_read(a), rdata);
        if (expected_region(a) != mem_pkg::REGION_MEMORY) begin
            check_split(1'b0, a, '0, '0);
        end else if (expect_hit) begin
            check_value("bus strobes", 64'd0, 64'(log_addr.size()));
            check_value("hit latency", 64'd1, 64'(cycles));
        end else begin
            check_value("bus strobes", 64'd1, 64'(log_addr.size()));
            if (log_addr.size() == 1) begin
                check_flag(!log_we[0], "miss issued a bus write instead of a read");
                check_value("refill addr", {a[63:3], 3'b000}, log_addr[0]);
            end
        end
    endtask

    task automatic write_and_check(input logic [63:0] a, input logic [63:0] wdata,
                                   input logic [7:0] mask);
        logic [63:0] rdata;
        int          cycles;
        run_access(1'b1, a, wdata, mask, rdata, cycles);
        ref_write(a, wdata, mask);
        if (expected_region(a) != mem_pkg::REGION_MEMORY) begin
            check_split(1'b1, a, wdata, mask);
        end else begin
            check_value("bus strobes", 64'd1, 64'(log_addr.size()));
            if (log_addr.size() == 1) begin
                check_flag(log_we[0], "write-through issued a bus read");
                check_value("bus addr", a, log_addr[0]);
                check_value("bus wdata", wdata, log_wdata[0]);
                check_value("bus mask", 64'(mask), 64'(log_mask[0]));
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset && (bus_we || bus_re)) begin
            log_addr.push_back(bus_addr);
            log_wdata.push_back(bus_wdata);
            log_mask.push_back(bus_mask);
            log_we.push_back(bus_we);
        end
    end

    // region is only meaningful with a strobe, memory otherwise
    always @(negedge clk) begin : region_check
        mem_pkg::access_region_e want;
        want = (core_we || core_re) ? expected_region(core_addr) : mem_pkg::REGION_MEMORY;
        if (!reset)
            assert (core_region == want)
            else begin
                $display("mismatch %s region: expected %0d, actual %0d", test_name, want,
                         core_region);
                errors++;
            end
    end

    fence_latency: assert property (@(posedge clk) disable iff (reset)
        core_fence |=> core_finish)
    else begin
        $display("%s: fence did not finish one cycle after its strobe", test_name);
        errors++;
    end

    device_bypass: assert property (@(posedge clk) disable iff (reset)
        ((core_we || core_re) && expected_region(core_addr) != mem_pkg::REGION_MEMORY)
            |-> !(dut0.cache_req.we || dut0.cache_req.re))
    else begin
        $display("%s: the cache received a device access", test_name);
        errors++;
    end

    initial begin
        repeat (16 + 200 * num_accesses) @(posedge clk);
        $display("watchdog expired, an access never finished");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : stimulus
        int cycles;
        seed         = seed_value;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        reset        = 1'b1;
        core_addr    = '0;
        core_wdata   = '0;
        core_mask    = '0;
        core_we      = 1'b0;
        core_re      = 1'b0;
        core_fence   = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        begin_test("read_miss_then_hit");
        read_and_check(addr_a, 1'b0);
        read_and_check(addr_a, 1'b1);
        end_test();

        begin_test("write_through_hit");
        write_and_check(addr_a, {$random(seed), $random(seed)}, 8'b1010_0110);
        read_and_check(addr_a, 1'b1);
        end_test();

        begin_test("write_through_miss");
        write_and_check(addr_b, {$random(seed), $random(seed)}, 8'b0011_1100);
        read_and_check(addr_b, 1'b0);  // writes do not allocate
        end_test();

        begin_test("uncached_read_split");
        read_and_check(addr_uart, 1'b0);
        end_test();

        begin_test("uncached_write_split");
        write_and_check(addr_spictrl, {$random(seed), $random(seed)}, 8'b1101_0011);
        read_and_check(addr_spictrl, 1'b0);
        end_test();

        begin_test("region_report");
        read_and_check(addr_clint, 1'b0);
        read_and_check(addr_spi, 1'b0);
        read_and_check(addr_low, 1'b0);
        end_test();

        begin_test("fence_invalidate");
        run_fence(cycles);
        check_value("fence latency", 64'd1, 64'(cycles));
        check_value("fence bus strobes", 64'd0, 64'(log_addr.size()));
        read_and_check(addr_a, 1'b0);
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== bench/bus_slave_model.sv ====
`timescale 1ns/1ns
`include "mem_macros.svh"

// bus responder with doubleword memory outside the device windows and 32-bit registers inside
module bus_slave_model #(
    parameter logic [31:0] seed_init = 32'h1fd5_16e8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`MEM_XLEN-1:0]   bus_addr,
    input  logic [`MEM_XLEN-1:0]   bus_wdata,
    input  logic [`MEM_MASK_W-1:0] bus_mask,
    input  logic                   bus_we,
    input  logic                   bus_re,
    output logic [`MEM_XLEN-1:0]   bus_rdata,
    output logic                   bus_finish
);
    logic [31:0]            words [logic [61:0]];  // sparse, keyed by 32-bit word index
    integer                 seed;
    logic                   busy;
    int                     delay;
    logic [`MEM_XLEN-1:0]   req_addr;
    logic [`MEM_XLEN-1:0]   req_wdata;
    logic [`MEM_MASK_W-1:0] req_mask;
    logic                   req_we;

    initial seed = seed_init;

    // untouched words read back a pattern built from every address bit
    function automatic logic [31:0] fill_word(input logic [61:0] w);
        return w[31:0] ^ {2'b00, w[61:32]} ^ 32'h5ac3_0f69;
    endfunction

    function automatic logic [31:0] word_at(input logic [61:0] w);
        return words.exists(w) ? words[w] : fill_word(w);
    endfunction

    function automatic logic is_device(input logic [`MEM_XLEN-1:0] a);
        return (a >= `MEM_UART_START && a <= `MEM_UART_END) ||
               (a >= `MEM_SPICTRL_START && a <= `MEM_SPICTRL_END) ||
               (a >= `MEM_SPI_START && a <= `MEM_SPI_END) ||
               (a >= `MEM_CLINT_START && a <= `MEM_CLINT_END);
    endfunction

    task automatic write_word(input logic [61:0] w, input logic [31:0] data,
                              input logic [3:0] en);
        logic [31:0] cur;
        cur = word_at(w);
        for (int i = 0; i < 4; i++)
            if (en[i])
                cur[i*8 +: 8] = data[i*8 +: 8];
        words[w] = cur;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            bus_finish <= 1'b0;
            bus_rdata  <= '0;
        end else begin
            bus_finish <= 1'b0;
            if (bus_we || bus_re) begin
                busy      <= 1'b1;
                delay     <= 1 + int'({$random(seed)} % 4);  // one to four cycles
                req_addr  <= bus_addr;
                req_wdata <= bus_wdata;
                req_mask  <= bus_mask;
                req_we    <= bus_we;
            end else if (busy) begin
                if (delay > 1) begin
                    delay <= delay - 1;
                end else begin
                    busy       <= 1'b0;
                    bus_finish <= 1'b1;
                    if (req_we && is_device(req_addr)) begin
                        write_word(req_addr[63:2], req_wdata[31:0], req_mask[3:0]);
                    end else if (req_we) begin
                        write_word({req_addr[63:3], 1'b0}, req_wdata[31:0], req_mask[3:0]);
                        write_word({req_addr[63:3], 1'b1}, req_wdata[63:32], req_mask[7:4]);
                    end else if (is_device(req_addr)) begin
                        bus_rdata <= {32'h0, word_at(req_addr[63:2])};
                    end else begin
                        bus_rdata <= {word_at({req_addr[63:3], 1'b1}),
                                      word_at({req_addr[63:3], 1'b0})};
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/1ns
`include "mem_macros.svh"

module mem_subsys_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`MEM_XLEN-1:0]    core_addr,
    input  logic [`MEM_XLEN-1:0]    core_wdata,
    input  logic [`MEM_MASK_W-1:0]  core_mask,
    input  logic                    core_we,
    input  logic                    core_re,
    input  logic                    core_fence,
    output logic [`MEM_XLEN-1:0]    core_rdata,
    output logic                    core_finish,
    output mem_pkg::access_region_e core_region,
    output logic [`MEM_XLEN-1:0]    bus_addr,
    output logic [`MEM_XLEN-1:0]    bus_wdata,
    output logic [`MEM_MASK_W-1:0]  bus_mask,
    output logic                    bus_we,
    output logic                    bus_re,
    input  logic [`MEM_XLEN-1:0]    bus_rdata,
    input  logic                    bus_finish
);
    logic cache_fence;

    mem_req_if cache_req ();
    mem_req_if cache_bus ();
    mem_req_if mmio_bus ();

    mmio_router u_router (
        .clk         (clk),
        .reset       (reset),
        .core_addr   (core_addr),
        .core_wdata  (core_wdata),
        .core_mask   (core_mask),
        .core_we     (core_we),
        .core_re     (core_re),
        .core_fence  (core_fence),
        .core_rdata  (core_rdata),
        .core_finish (core_finish),
        .core_region (core_region),
        .cache_fence (cache_fence),
        .cache_req   (cache_req.requester),
        .mmio_bus    (mmio_bus.requester)
    );

    data_cache u_cache (
        .clk   (clk),
        .reset (reset),
        .fence (cache_fence),
        .cpu   (cache_req.responder),
        .bus   (cache_bus.requester)
    );

    bus_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .cache_side (cache_bus.responder),
        .mmio_side  (mmio_bus.responder),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_mask   (bus_mask),
        .bus_we     (bus_we),
        .bus_re     (bus_re),
        .bus_rdata  (bus_rdata),
        .bus_finish (bus_finish)
    );

endmodule

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/1ns
`include "mem_macros.svh"

module bus_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    mem_req_if.responder           cache_side,
    mem_req_if.responder           mmio_side,
    output logic [`MEM_XLEN-1:0]   bus_addr,
    output logic [`MEM_XLEN-1:0]   bus_wdata,
    output logic [`MEM_MASK_W-1:0] bus_mask,
    output logic                   bus_we,
    output logic                   bus_re,
    input  logic [`MEM_XLEN-1:0]   bus_rdata,
    input  logic                   bus_finish
);
    mem_pkg::bus_owner_e    owner;
    logic                   bus_free;
    logic                   c_strobe, c_pend, c_want, c_issue, c_we;
    logic                   m_strobe, m_pend, m_want, m_issue, m_we;
    logic [`MEM_XLEN-1:0]   c_addr, c_wdata, m_addr, m_wdata;
    logic [`MEM_MASK_W-1:0] c_mask, m_mask;
    logic [`MEM_XLEN-1:0]   sel_addr, sel_wdata;
    logic [`MEM_MASK_W-1:0] sel_mask;
    logic                   sel_we;

    assign c_strobe = cache_side.we | cache_side.re;
    assign m_strobe = mmio_side.we | mmio_side.re;
    assign c_want   = c_pend | c_strobe;
    assign m_want   = m_pend | m_strobe;
    assign bus_free = (owner == mem_pkg::OWNER_NONE) || bus_finish;  // next beat may follow a finish
    assign c_issue  = bus_free && c_want;
    assign m_issue  = bus_free && !c_want && m_want;  // cache wins a tie

    always_comb begin
        if (c_want) begin
            sel_addr  = c_strobe ? cache_side.addr  : c_addr;
            sel_wdata = c_strobe ? cache_side.wdata : c_wdata;
            sel_mask  = c_strobe ? cache_side.mask  : c_mask;
            sel_we    = c_strobe ? cache_side.we    : c_we;
        end else begin
            sel_addr  = m_strobe ? mmio_side.addr  : m_addr;
            sel_wdata = m_strobe ? mmio_side.wdata : m_wdata;
            sel_mask  = m_strobe ? mmio_side.mask  : m_mask;
            sel_we    = m_strobe ? mmio_side.we    : m_we;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            owner  <= mem_pkg::OWNER_NONE;
            c_pend <= 1'b0;
            m_pend <= 1'b0;
            bus_we <= 1'b0;
            bus_re <= 1'b0;
        end else begin
            bus_we <= 1'b0;
            bus_re <= 1'b0;
            if (c_issue || m_issue) begin
                bus_we <= sel_we;
                bus_re <= ~sel_we;
                owner  <= c_issue ? mem_pkg::OWNER_CACHE : mem_pkg::OWNER_MMIO;
            end else if (bus_finish) begin
                owner <= mem_pkg::OWNER_NONE;
            end
            c_pend <= c_want && !c_issue;
            m_pend <= m_want && !m_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (c_strobe) begin
            c_addr  <= cache_side.addr;
            c_wdata <= cache_side.wdata;
            c_mask  <= cache_side.mask;
            c_we    <= cache_side.we;
        end
        if (m_strobe) begin
            m_addr  <= mmio_side.addr;
            m_wdata <= mmio_side.wdata;
            m_mask  <= mmio_side.mask;
            m_we    <= mmio_side.we;
        end
        if (c_issue || m_issue) begin
            bus_addr  <= sel_addr;
            bus_wdata <= sel_wdata;
            bus_mask  <= sel_mask;
        end
    end

    // only the current owner sees the response
    assign cache_side.finish = bus_finish && (owner == mem_pkg::OWNER_CACHE);
    assign cache_side.rdata  = (owner == mem_pkg::OWNER_CACHE) ? bus_rdata : '0;
    assign mmio_side.finish  = bus_finish && (owner == mem_pkg::OWNER_MMIO);
    assign mmio_side.rdata   = (owner == mem_pkg::OWNER_MMIO) ? bus_rdata : '0;

endmodule

// ==== hdl/data_cache.sv ====
`timescale 1ns/1ns
`include "mem_macros.svh"

module data_cache (
    input  logic         clk,
    input  logic         reset,
    input  logic         fence,
    mem_req_if.responder cpu,
    mem_req_if.requester bus
);
    localparam int IDX_W = $clog2(`MEM_CACHE_LINES);
    localparam int TAG_W = `MEM_XLEN - 3 - IDX_W;

    logic [`MEM_CACHE_LINES-1:0] line_valid;
    logic [TAG_W-1:0]            line_tag [`MEM_CACHE_LINES];
    logic [`MEM_XLEN-1:0]        line_data [`MEM_CACHE_LINES];

    mem_pkg::cache_state_e       state;
    logic [IDX_W-1:0]            req_idx;
    logic [TAG_W-1:0]            req_tag;
    logic                        hit;
    logic [`MEM_XLEN-1:0]        merged;
    logic [IDX_W-1:0]            fill_idx;
    logic [TAG_W-1:0]            fill_tag;
    logic                        finish_q;
    logic [`MEM_XLEN-1:0]        rdata_q;
    logic [`MEM_XLEN-1:0]        bus_addr_q;
    logic [`MEM_XLEN-1:0]        bus_wdata_q;
    logic [`MEM_MASK_W-1:0]      bus_mask_q;
    logic                        bus_we_q;
    logic                        bus_re_q;

    // bits 2:0 select the byte inside the doubleword line
    assign req_idx = cpu.addr[3 +: IDX_W];
    assign req_tag = cpu.addr[`MEM_XLEN-1 -: TAG_W];
    assign hit     = line_valid[req_idx] && (line_tag[req_idx] == req_tag);

    always_comb begin
        merged = line_data[req_idx];
        for (int i = 0; i < `MEM_MASK_W; i++) begin
            if (cpu.mask[i])
                merged[i*8 +: 8] = cpu.wdata[i*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= mem_pkg::CACHE_IDLE;
            line_valid <= '0;
            finish_q   <= 1'b0;
            bus_we_q   <= 1'b0;
            bus_re_q   <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            bus_we_q <= 1'b0;
            bus_re_q <= 1'b0;
            case (state)
                mem_pkg::CACHE_IDLE: begin
                    if (fence) begin
                        line_valid <= '0;
                        finish_q   <= 1'b1;
                    end else if (cpu.re) begin
                        if (hit) begin
                            finish_q <= 1'b1;
                        end else begin
                            bus_re_q <= 1'b1;
                            state    <= mem_pkg::CACHE_REFILL;
                        end
                    end else if (cpu.we) begin
                        bus_we_q <= 1'b1;  // write-through, hit or miss
                        state    <= mem_pkg::CACHE_WRITE;
                    end
                end
                mem_pkg::CACHE_REFILL: begin
                    if (bus.finish) begin
                        line_valid[fill_idx] <= 1'b1;
                        finish_q             <= 1'b1;
                        state                <= mem_pkg::CACHE_IDLE;
                    end
                end
                mem_pkg::CACHE_WRITE: begin
                    if (bus.finish) begin
                        finish_q <= 1'b1;
                        state    <= mem_pkg::CACHE_IDLE;
                    end
                end
                default: state <= mem_pkg::CACHE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_pkg::CACHE_IDLE && !fence && (cpu.re || cpu.we)) begin
            // a refill fetches the whole aligned doubleword
            bus_addr_q  <= cpu.re ? {cpu.addr[`MEM_XLEN-1:3], 3'b000} : cpu.addr;
            bus_wdata_q <= cpu.wdata;
            bus_mask_q  <= cpu.mask;
            fill_idx    <= req_idx;
            fill_tag    <= req_tag;
        end
        if (state == mem_pkg::CACHE_IDLE && !fence && cpu.re && hit)
            rdata_q <= line_data[req_idx];
        if (state == mem_pkg::CACHE_IDLE && !fence && cpu.we && !cpu.re && hit)
            line_data[req_idx] <= merged;  // no allocation on a write miss
        if (state == mem_pkg::CACHE_REFILL && bus.finish) begin
            line_data[fill_idx] <= bus.rdata;
            line_tag[fill_idx]  <= fill_tag;
            rdata_q             <= bus.rdata;
        end
    end

    assign cpu.finish = finish_q;
    assign cpu.rdata  = rdata_q;

    assign bus.addr  = bus_addr_q;
    assign bus.wdata = bus_wdata_q;
    assign bus.mask  = bus_mask_q;
    assign bus.we    = bus_we_q;
    assign bus.re    = bus_re_q;

endmodule

// ==== hdl/mmio_router.sv ====
`timescale 1ns/1ns
`include "mem_macros.svh"

module mmio_router (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`MEM_XLEN-1:0]         core_addr,
    input  logic [`MEM_XLEN-1:0]         core_wdata,
    input  logic [`MEM_MASK_W-1:0]       core_mask,
    input  logic                         core_we,
    input  logic                         core_re,
    input  logic                         core_fence,
    output logic [`MEM_XLEN-1:0]         core_rdata,
    output logic                         core_finish,
    output mem_pkg::access_region_e      core_region,
    output logic                         cache_fence,
    mem_req_if.requester                 cache_req,
    mem_req_if.requester                 mmio_bus
);
    logic                      strobe;
    logic                      in_uart;
    logic                      in_spictrl;
    logic                      in_spi;
    logic                      in_clint;
    logic                      uncached;
    mem_pkg::split_state_e     state;
    logic [`MEM_XLEN-1:0]      base_addr;
    logic [31:0]               lo_wdata;
    logic [3:0]                lo_mask;
    logic                      uc_write;
    logic [`MEM_XLEN-1:0]      beat_addr;
    logic [31:0]               beat_wdata;
    logic [3:0]                beat_mask;
    logic                      beat_we;
    logic                      beat_re;
    logic [`MEM_XLEN-1:0]      uc_rdata;
    logic                      uc_finish;

    assign strobe     = core_we | core_re;
    assign in_uart    = (core_addr >= `MEM_UART_START) && (core_addr <= `MEM_UART_END);
    assign in_spictrl = (core_addr >= `MEM_SPICTRL_START) && (core_addr <= `MEM_SPICTRL_END);
    assign in_spi     = (core_addr >= `MEM_SPI_START) && (core_addr <= `MEM_SPI_END);
    assign in_clint   = (core_addr >= `MEM_CLINT_START) && (core_addr <= `MEM_CLINT_END);
    assign uncached   = in_uart | in_spictrl | in_spi | in_clint;

    always_comb begin
        if (strobe && in_clint)
            core_region = mem_pkg::REGION_CLINT;
        else if (strobe && uncached)
            core_region = mem_pkg::REGION_DEVICE;
        else
            core_region = mem_pkg::REGION_MEMORY;
    end

    // cacheable accesses and the fence go straight on to the cache
    assign cache_fence     = core_fence;
    assign cache_req.addr  = core_addr;
    assign cache_req.wdata = core_wdata;
    assign cache_req.mask  = core_mask;
    assign cache_req.we    = core_we & ~uncached;
    assign cache_req.re    = core_re & ~uncached;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= mem_pkg::SPLIT_IDLE;
            beat_we   <= 1'b0;
            beat_re   <= 1'b0;
            uc_finish <= 1'b0;
        end else begin
            beat_we   <= 1'b0;
            beat_re   <= 1'b0;
            uc_finish <= 1'b0;
            case (state)
                mem_pkg::SPLIT_IDLE: begin
                    if (strobe && uncached) begin
                        beat_we <= core_we;
                        beat_re <= core_re;
                        state   <= mem_pkg::SPLIT_HIGH;
                    end
                end
                mem_pkg::SPLIT_HIGH: begin
                    if (mmio_bus.finish) begin
                        beat_we <= uc_write;
                        beat_re <= ~uc_write;
                        state   <= mem_pkg::SPLIT_LOW;
                    end
                end
                mem_pkg::SPLIT_LOW: begin
                    if (mmio_bus.finish) begin
                        uc_finish <= 1'b1;  // core sees it one cycle after the last beat
                        state     <= mem_pkg::SPLIT_IDLE;
                    end
                end
                default: state <= mem_pkg::SPLIT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_pkg::SPLIT_IDLE && strobe && uncached) begin
            base_addr  <= {core_addr[`MEM_XLEN-1:3], 3'b000};
            lo_wdata   <= core_wdata[31:0];
            lo_mask    <= core_mask[3:0];
            uc_write   <= core_we;
            beat_addr  <= {core_addr[`MEM_XLEN-1:3], 3'b100};  // high word lives at base+4
            beat_wdata <= core_wdata[63:32];
            beat_mask  <= core_mask[7:4];
        end
        if (state == mem_pkg::SPLIT_HIGH && mmio_bus.finish) begin
            uc_rdata[63:32] <= mmio_bus.rdata[31:0];
            beat_addr       <= base_addr;
            beat_wdata      <= lo_wdata;
            beat_mask       <= lo_mask;
        end
        if (state == mem_pkg::SPLIT_LOW && mmio_bus.finish)
            uc_rdata[31:0] <= mmio_bus.rdata[31:0];
    end

    // devices see 32-bit registers on the low lanes of the bus
    assign mmio_bus.addr  = beat_addr;
    assign mmio_bus.wdata = {32'h0, beat_wdata};
    assign mmio_bus.mask  = {4'h0, beat_mask};
    assign mmio_bus.we    = beat_we;
    assign mmio_bus.re    = beat_re;

    assign core_rdata  = uc_finish ? uc_rdata : cache_req.rdata;
    assign core_finish = uc_finish | cache_req.finish;

endmodule

// ==== hdl/mem_req_if.sv ====
`timescale 1ns/1ns
`include "mem_macros.svh"

// one strobe-handshake channel, request fields are only valid with we or re
interface mem_req_if;
    logic [`MEM_XLEN-1:0]   addr;
    logic [`MEM_XLEN-1:0]   wdata;
    logic [`MEM_MASK_W-1:0] mask;
    logic                   we;
    logic                   re;
    logic [`MEM_XLEN-1:0]   rdata;
    logic                   finish;  // one cycle, rdata valid with it on reads

    modport requester (
        output addr, wdata, mask, we, re,
        input  rdata, finish
    );

    modport responder (
        input  addr, wdata, mask, we, re,
        output rdata, finish
    );
endinterface

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

    // which part of the address map a core access falls into
    typedef enum logic [1:0] {
        REGION_MEMORY = 2'd0,
        REGION_DEVICE = 2'd1,
        REGION_CLINT  = 2'd2
    } access_region_e;

    // uncached splitter, the high word always goes out first
    typedef enum logic [1:0] {
        SPLIT_IDLE = 2'd0,
        SPLIT_HIGH = 2'd1,
        SPLIT_LOW  = 2'd2
    } split_state_e;

    typedef enum logic [1:0] {
        CACHE_IDLE   = 2'd0,
        CACHE_REFILL = 2'd1,
        CACHE_WRITE  = 2'd2
    } cache_state_e;

    typedef enum logic [1:0] {
        OWNER_NONE  = 2'd0,
        OWNER_CACHE = 2'd1,
        OWNER_MMIO  = 2'd2
    } bus_owner_e;

endpackage

// ==== hdl/mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// data path and byte-enable widths of the core port and the system bus
`define MEM_XLEN   64
`define MEM_MASK_W 8

// device windows, everything outside them is cacheable memory
`define MEM_UART_START    64'h0000_0000_1000_0000
`define MEM_UART_END      64'h0000_0000_1000_0fff
`define MEM_SPICTRL_START 64'h0000_0000_1000_1000
`define MEM_SPICTRL_END   64'h0000_0000_1000_1fff
`define MEM_SPI_START     64'h0000_0000_3000_0000
`define MEM_SPI_END       64'h0000_0000_3fff_ffff
`define MEM_CLINT_START   64'h0000_0000_0200_0000
`define MEM_CLINT_END     64'h0000_0000_0200_ffff

// number of one-doubleword lines, keep it a power of two
`define MEM_CACHE_LINES 16

`endif
